//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath width, shared by data words and PCs
`define CORE_XLEN 32

// Architectural register file
`define CORE_NREGS 32
`define CORE_RADDR_W 5

// Register file read ports, two per decode slot
`define CORE_READ_PORTS 4

// Exception code width and the code for TLB refill
`define CORE_ECODE_W 6
`define CORE_ECODE_TLBR 6'h3F

// Instructions retired per cycle
`define CORE_COMMIT_W 2

`endif

//--- hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // One architectural data word
    typedef logic [`CORE_XLEN-1:0] word_t;

    // Instruction address
    typedef logic [`CORE_XLEN-1:0] pc_t;

    // Register number
    typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

    // Exception code as carried down the pipe
    typedef logic [`CORE_ECODE_W-1:0] ecode_t;

    // What a slot does when it reaches commit
    typedef enum logic [1:0] {
        CK_NORMAL = 2'd0,
        CK_EXCP   = 2'd1,
        CK_ERTN   = 2'd2
    } commit_kind_e;

endpackage

//--- hw/wb_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module wb_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,

    input  logic                       stall_i,
    input  logic                       flush_i,

    // Slots from the memory stage, slot 0 is older
    input  logic [`CORE_COMMIT_W-1:0]  mem_valid_i,
    input  core_pkg::pc_t              mem_pc_i    [`CORE_COMMIT_W],
    input  core_pkg::commit_kind_e     mem_kind_i  [`CORE_COMMIT_W],
    input  core_pkg::ecode_t           mem_ecode_i [`CORE_COMMIT_W],
    input  logic [`CORE_COMMIT_W-1:0]  mem_we_i,
    input  core_pkg::reg_addr_t        mem_waddr_i [`CORE_COMMIT_W],
    input  core_pkg::word_t            mem_wdata_i [`CORE_COMMIT_W],

    // Registered slots towards commit
    output logic [`CORE_COMMIT_W-1:0]  wb_valid_o,
    output core_pkg::pc_t              wb_pc_o    [`CORE_COMMIT_W],
    output core_pkg::commit_kind_e     wb_kind_o  [`CORE_COMMIT_W],
    output core_pkg::ecode_t           wb_ecode_o [`CORE_COMMIT_W],
    output logic [`CORE_COMMIT_W-1:0]  wb_we_o,
    output core_pkg::reg_addr_t        wb_waddr_o [`CORE_COMMIT_W],
    output core_pkg::word_t            wb_wdata_o [`CORE_COMMIT_W]
);

    logic bubble;

    // Mem stall or commit flush both empty the stage
    assign bubble = stall_i | flush_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= '0;
        end else if (bubble) begin
            wb_valid_o <= '0;
        end else begin
            wb_valid_o <= mem_valid_i;
        end
    end

    // Payload is only looked at when the matching valid bit is set
    always_ff @(posedge clk) begin
        wb_we_o <= mem_we_i;
        for (int i = 0; i < `CORE_COMMIT_W; i++) begin
            wb_pc_o[i]    <= mem_pc_i[i];
            wb_kind_o[i]  <= mem_kind_i[i];
            wb_ecode_o[i] <= mem_ecode_i[i];
            wb_waddr_o[i] <= mem_waddr_i[i];
            wb_wdata_o[i] <= mem_wdata_i[i];
        end
    end

    // Nothing younger than a flushing instruction may reach commit
    a_flush_bubble: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (wb_valid_o == '0)
    );

endmodule

//--- hw/commit_ctrl.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module commit_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,

    // Slots from the writeback register
    input  logic [`CORE_COMMIT_W-1:0]  wb_valid_i,
    input  core_pkg::pc_t              wb_pc_i    [`CORE_COMMIT_W],
    input  core_pkg::commit_kind_e     wb_kind_i  [`CORE_COMMIT_W],
    input  core_pkg::ecode_t           wb_ecode_i [`CORE_COMMIT_W],
    input  logic [`CORE_COMMIT_W-1:0]  wb_we_i,
    input  core_pkg::reg_addr_t        wb_waddr_i [`CORE_COMMIT_W],
    input  core_pkg::word_t            wb_wdata_i [`CORE_COMMIT_W],

    // Branch resolution and exception entries
    input  logic [`CORE_COMMIT_W-1:0]  branch_flag_i,
    input  core_pkg::pc_t              branch_target_i [`CORE_COMMIT_W],
    input  core_pkg::pc_t              eentry_i,
    input  core_pkg::pc_t              tlbrentry_i,

    // Register file write ports
    output logic [`CORE_COMMIT_W-1:0]  rf_we_o,
    output core_pkg::reg_addr_t        rf_waddr_o [`CORE_COMMIT_W],
    output core_pkg::word_t            rf_wdata_o [`CORE_COMMIT_W],

    output logic                       flush_o,
    output logic                       backend_flush_o,
    output core_pkg::pc_t              next_pc_o,
    output core_pkg::pc_t              era_o,

    // Commit trace
    output core_pkg::pc_t              debug0_wb_pc_o,
    output logic [3:0]                 debug0_wb_rf_wen_o,
    output core_pkg::reg_addr_t        debug0_wb_rf_wnum_o,
    output core_pkg::word_t            debug0_wb_rf_wdata_o,
    output core_pkg::pc_t              debug1_wb_pc_o,
    output logic [3:0]                 debug1_wb_rf_wen_o,
    output core_pkg::reg_addr_t        debug1_wb_rf_wnum_o,
    output core_pkg::word_t            debug1_wb_rf_wdata_o
);

    logic [`CORE_COMMIT_W-1:0] slot_live;
    logic [`CORE_COMMIT_W-1:0] retire;
    logic [`CORE_COMMIT_W-1:0] excp_slot;
    logic [`CORE_COMMIT_W-1:0] ertn_slot;
    logic                      excp_flush;
    logic                      ertn_flush;
    core_pkg::pc_t             excp_pc;
    core_pkg::ecode_t          excp_ecode;

    // Slot 1 only counts when slot 0 does not redirect
    assign slot_live[0] = wb_valid_i[0];
    assign slot_live[1] = wb_valid_i[1] &
                          (!wb_valid_i[0] || wb_kind_i[0] == core_pkg::CK_NORMAL);

    always_comb begin
        for (int i = 0; i < `CORE_COMMIT_W; i++) begin
            retire[i]    = slot_live[i] && wb_kind_i[i] == core_pkg::CK_NORMAL;
            excp_slot[i] = slot_live[i] && wb_kind_i[i] == core_pkg::CK_EXCP;
            ertn_slot[i] = slot_live[i] && wb_kind_i[i] == core_pkg::CK_ERTN;
        end
    end

    assign excp_flush = |excp_slot;
    assign ertn_flush = |ertn_slot;
    assign flush_o    = excp_flush | ertn_flush;

    // Oldest excepting slot wins
    assign excp_pc    = excp_slot[0] ? wb_pc_i[0] : wb_pc_i[1];
    assign excp_ecode = excp_slot[0] ? wb_ecode_i[0] : wb_ecode_i[1];

    assign rf_we_o    = retire & wb_we_i;
    assign rf_waddr_o = wb_waddr_i;
    assign rf_wdata_o = wb_wdata_i;

    assign backend_flush_o = (|branch_flag_i) | excp_flush | ertn_flush;

    always_comb begin
        if (branch_flag_i[0]) begin
            next_pc_o = branch_target_i[0];
        end else if (branch_flag_i[1]) begin
            next_pc_o = branch_target_i[1];
        end else if (excp_flush) begin
            next_pc_o = (excp_ecode == `CORE_ECODE_TLBR) ? tlbrentry_i : eentry_i;
        end else if (ertn_flush) begin
            next_pc_o = era_o;
        end else begin
            next_pc_o = '0;
        end
    end

    // Exception return address
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            era_o <= '0;
        end else if (excp_flush) begin
            era_o <= excp_pc;
        end
    end

    // Trace fields hold the last retired slot, wen pulses per write
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            debug0_wb_pc_o       <= '0;
            debug0_wb_rf_wen_o   <= '0;
            debug0_wb_rf_wnum_o  <= '0;
            debug0_wb_rf_wdata_o <= '0;
            debug1_wb_pc_o       <= '0;
            debug1_wb_rf_wen_o   <= '0;
            debug1_wb_rf_wnum_o  <= '0;
            debug1_wb_rf_wdata_o <= '0;
        end else begin
            debug0_wb_rf_wen_o <= {3'b000, rf_we_o[0]};
            debug1_wb_rf_wen_o <= {3'b000, rf_we_o[1]};
            if (retire[0]) begin
                debug0_wb_pc_o       <= wb_pc_i[0];
                debug0_wb_rf_wnum_o  <= wb_waddr_i[0];
                debug0_wb_rf_wdata_o <= wb_wdata_i[0];
            end
            if (retire[1]) begin
                debug1_wb_pc_o       <= wb_pc_i[1];
                debug1_wb_rf_wnum_o  <= wb_waddr_i[1];
                debug1_wb_rf_wdata_o <= wb_wdata_i[1];
            end
        end
    end

    // Exception and return in one cycle would corrupt era and the redirect
    a_excp_ertn_excl: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        !(excp_flush && ertn_flush)
    );

endmodule

//--- hw/regfile.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module regfile (
    input  logic                       clk,
    input  logic                       rst_n_i,

    // Write ports, port 1 carries the younger slot
    input  logic [`CORE_COMMIT_W-1:0]  we_i,
    input  core_pkg::reg_addr_t        waddr_i [`CORE_COMMIT_W],
    input  core_pkg::word_t            wdata_i [`CORE_COMMIT_W],

    // Combinational read ports
    input  core_pkg::reg_addr_t        raddr_i [`CORE_READ_PORTS],
    output core_pkg::word_t            rdata_o [`CORE_READ_PORTS]
);

    core_pkg::word_t regs [`CORE_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < `CORE_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Younger port applied last so it wins on a shared destination
            for (int p = 0; p < `CORE_COMMIT_W; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    // No write-through, a write is visible after its edge
    always_comb begin
        for (int p = 0; p < `CORE_READ_PORTS; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
        end
    end

    // r0 reads straight from storage, so it must never be written
    a_r0_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        regs[0] == '0
    );

endmodule

//--- hw/commit_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module commit_top (
    input  logic                       clk,
    input  logic                       rst_n_i,

    input  logic [`CORE_COMMIT_W-1:0]  mem_valid_i,
    input  core_pkg::pc_t              mem_pc_i    [`CORE_COMMIT_W],
    input  core_pkg::commit_kind_e     mem_kind_i  [`CORE_COMMIT_W],
    input  core_pkg::ecode_t           mem_ecode_i [`CORE_COMMIT_W],
    input  logic [`CORE_COMMIT_W-1:0]  mem_we_i,
    input  core_pkg::reg_addr_t        mem_waddr_i [`CORE_COMMIT_W],
    input  core_pkg::word_t            mem_wdata_i [`CORE_COMMIT_W],
    input  logic                       stall_i,

    input  logic [`CORE_COMMIT_W-1:0]  branch_flag_i,
    input  core_pkg::pc_t              branch_target_i [`CORE_COMMIT_W],
    input  core_pkg::pc_t              eentry_i,
    input  core_pkg::pc_t              tlbrentry_i,

    input  core_pkg::reg_addr_t        raddr_i [`CORE_READ_PORTS],
    output core_pkg::word_t            rdata_o [`CORE_READ_PORTS],

    output logic                       backend_flush_o,
    output core_pkg::pc_t              next_pc_o,
    output core_pkg::pc_t              era_o,

    output core_pkg::pc_t              debug0_wb_pc_o,
    output logic [3:0]                 debug0_wb_rf_wen_o,
    output core_pkg::reg_addr_t        debug0_wb_rf_wnum_o,
    output core_pkg::word_t            debug0_wb_rf_wdata_o,
    output core_pkg::pc_t              debug1_wb_pc_o,
    output logic [3:0]                 debug1_wb_rf_wen_o,
    output core_pkg::reg_addr_t        debug1_wb_rf_wnum_o,
    output core_pkg::word_t            debug1_wb_rf_wdata_o
);

    // Writeback register -> commit
    logic [`CORE_COMMIT_W-1:0] wb_valid;
    core_pkg::pc_t             wb_pc    [`CORE_COMMIT_W];
    core_pkg::commit_kind_e    wb_kind  [`CORE_COMMIT_W];
    core_pkg::ecode_t          wb_ecode [`CORE_COMMIT_W];
    logic [`CORE_COMMIT_W-1:0] wb_we;
    core_pkg::reg_addr_t       wb_waddr [`CORE_COMMIT_W];
    core_pkg::word_t           wb_wdata [`CORE_COMMIT_W];

    // Commit -> register file and back to writeback
    logic [`CORE_COMMIT_W-1:0] rf_we;
    core_pkg::reg_addr_t       rf_waddr [`CORE_COMMIT_W];
    core_pkg::word_t           rf_wdata [`CORE_COMMIT_W];
    logic                      commit_flush;

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (commit_flush),
        .mem_valid_i (mem_valid_i),
        .mem_pc_i    (mem_pc_i),
        .mem_kind_i  (mem_kind_i),
        .mem_ecode_i (mem_ecode_i),
        .mem_we_i    (mem_we_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .wb_valid_o  (wb_valid),
        .wb_pc_o     (wb_pc),
        .wb_kind_o   (wb_kind),
        .wb_ecode_o  (wb_ecode),
        .wb_we_o     (wb_we),
        .wb_waddr_o  (wb_waddr),
        .wb_wdata_o  (wb_wdata)
    );

    commit_ctrl u_commit_ctrl (
        .clk                  (clk),
        .rst_n_i              (rst_n_i),
        .wb_valid_i           (wb_valid),
        .wb_pc_i              (wb_pc),
        .wb_kind_i            (wb_kind),
        .wb_ecode_i           (wb_ecode),
        .wb_we_i              (wb_we),
        .wb_waddr_i           (wb_waddr),
        .wb_wdata_i           (wb_wdata),
        .branch_flag_i        (branch_flag_i),
        .branch_target_i      (branch_target_i),
        .eentry_i             (eentry_i),
        .tlbrentry_i          (tlbrentry_i),
        .rf_we_o              (rf_we),
        .rf_waddr_o           (rf_waddr),
        .rf_wdata_o           (rf_wdata),
        .flush_o              (commit_flush),
        .backend_flush_o      (backend_flush_o),
        .next_pc_o            (next_pc_o),
        .era_o                (era_o),
        .debug0_wb_pc_o       (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o   (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o  (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o (debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o       (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o   (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o  (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o (debug1_wb_rf_wdata_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (raddr_i),
        .rdata_o (rdata_o)
    );

endmodule

//--- testbench/tb_commit_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_commit_top;

    logic                      clk;
    logic                      rst_n;
    logic [1:0]                mem_valid;
    core_pkg::pc_t             mem_pc    [`CORE_COMMIT_W];
    core_pkg::commit_kind_e    mem_kind  [`CORE_COMMIT_W];
    core_pkg::ecode_t          mem_ecode [`CORE_COMMIT_W];
    logic [1:0]                mem_we;
    core_pkg::reg_addr_t       mem_waddr [`CORE_COMMIT_W];
    core_pkg::word_t           mem_wdata [`CORE_COMMIT_W];
    logic                      stall;
    logic [1:0]                branch_flag;
    core_pkg::pc_t             branch_target [`CORE_COMMIT_W];
    core_pkg::pc_t             eentry;
    core_pkg::pc_t             tlbrentry;
    core_pkg::reg_addr_t       raddr [`CORE_READ_PORTS] = '{default: '0};
    core_pkg::word_t           rdata [`CORE_READ_PORTS];
    logic                      backend_flush;
    core_pkg::pc_t             next_pc;
    core_pkg::pc_t             era;
    core_pkg::pc_t             dbg_pc    [`CORE_COMMIT_W];
    logic [3:0]                dbg_wen   [`CORE_COMMIT_W];
    core_pkg::reg_addr_t       dbg_wnum  [`CORE_COMMIT_W];
    core_pkg::word_t           dbg_wdata [`CORE_COMMIT_W];

    // Reference model state
    logic [1:0]                m_valid;
    core_pkg::pc_t             m_pc    [`CORE_COMMIT_W];
    core_pkg::commit_kind_e    m_kind  [`CORE_COMMIT_W];
    core_pkg::ecode_t          m_ecode [`CORE_COMMIT_W];
    logic [1:0]                m_we;
    core_pkg::reg_addr_t       m_waddr [`CORE_COMMIT_W];
    core_pkg::word_t           m_wdata [`CORE_COMMIT_W];
    core_pkg::word_t           m_regs  [`CORE_NREGS];
    core_pkg::pc_t             m_era;
    core_pkg::pc_t             m_dbg_pc    [`CORE_COMMIT_W];
    logic [3:0]                m_dbg_wen   [`CORE_COMMIT_W];
    core_pkg::reg_addr_t       m_dbg_wnum  [`CORE_COMMIT_W];
    core_pkg::word_t           m_dbg_wdata [`CORE_COMMIT_W];
    logic [1:0]                c_retire;
    logic                      c_excp;
    logic                      c_ertn;
    logic                      younger_killed;
    core_pkg::pc_t             c_excp_pc;
    core_pkg::ecode_t          c_excp_ecode;
    core_pkg::pc_t             exp_next_pc;
    logic                      exp_backend_flush;

    int                        seed;
    int                        err_count;
    int                        timeout_count;
    string                     test_name;
    core_pkg::reg_addr_t       sweep_addr = '0;

    commit_top i_dut (
        .clk (clk), .rst_n_i (rst_n),
        .mem_valid_i (mem_valid), .mem_pc_i (mem_pc), .mem_kind_i (mem_kind),
        .mem_ecode_i (mem_ecode), .mem_we_i (mem_we), .mem_waddr_i (mem_waddr),
        .mem_wdata_i (mem_wdata), .stall_i (stall),
        .branch_flag_i (branch_flag), .branch_target_i (branch_target),
        .eentry_i (eentry), .tlbrentry_i (tlbrentry),
        .raddr_i (raddr), .rdata_o (rdata),
        .backend_flush_o (backend_flush), .next_pc_o (next_pc), .era_o (era),
        .debug0_wb_pc_o (dbg_pc[0]), .debug0_wb_rf_wen_o (dbg_wen[0]),
        .debug0_wb_rf_wnum_o (dbg_wnum[0]), .debug0_wb_rf_wdata_o (dbg_wdata[0]),
        .debug1_wb_pc_o (dbg_pc[1]), .debug1_wb_rf_wen_o (dbg_wen[1]),
        .debug1_wb_rf_wnum_o (dbg_wnum[1]), .debug1_wb_rf_wdata_o (dbg_wdata[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Older redirecting slot kills everything younger
    always_comb begin
        c_retire = '0;
        c_excp = 1'b0;
        c_ertn = 1'b0;
        c_excp_pc = '0;
        c_excp_ecode = '0;
        younger_killed = 1'b0;
        for (int i = 0; i < `CORE_COMMIT_W; i++) begin
            if (m_valid[i] && !younger_killed) begin
                if (m_kind[i] == core_pkg::CK_NORMAL) begin
                    c_retire[i] = 1'b1;
                end else if (m_kind[i] == core_pkg::CK_EXCP) begin
                    c_excp = 1'b1;
                    c_excp_pc = m_pc[i];
                    c_excp_ecode = m_ecode[i];
                    younger_killed = 1'b1;
                end else begin
                    c_ertn = 1'b1;
                    younger_killed = 1'b1;
                end
            end
        end
        if (branch_flag[0]) begin
            exp_next_pc = branch_target[0];
        end else if (branch_flag[1]) begin
            exp_next_pc = branch_target[1];
        end else if (c_excp) begin
            exp_next_pc = (c_excp_ecode == 6'h3F) ? tlbrentry : eentry;
        end else if (c_ertn) begin
            exp_next_pc = m_era;
        end else begin
            exp_next_pc = '0;
        end
        exp_backend_flush = (|branch_flag) | c_excp | c_ertn;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= '0;
            m_we <= '0;
            m_era <= '0;
            for (int r = 0; r < `CORE_NREGS; r++) begin
                m_regs[r] <= '0;
            end
            for (int s = 0; s < `CORE_COMMIT_W; s++) begin
                m_waddr[s] <= '0;
                m_dbg_pc[s] <= '0;
                m_dbg_wen[s] <= '0;
                m_dbg_wnum[s] <= '0;
                m_dbg_wdata[s] <= '0;
            end
        end else begin
            m_valid <= (stall || c_excp || c_ertn) ? 2'b00 : mem_valid;
            m_we <= mem_we;
            for (int s = 0; s < `CORE_COMMIT_W; s++) begin
                m_pc[s] <= mem_pc[s];
                m_kind[s] <= mem_kind[s];
                m_ecode[s] <= mem_ecode[s];
                m_waddr[s] <= mem_waddr[s];
                m_wdata[s] <= mem_wdata[s];
                m_dbg_wen[s] <= (c_retire[s] && m_we[s]) ? 4'b0001 : 4'b0000;
                if (c_retire[s]) begin
                    m_dbg_pc[s] <= m_pc[s];
                    m_dbg_wnum[s] <= m_waddr[s];
                    m_dbg_wdata[s] <= m_wdata[s];
                    // Slot 1 is applied last and wins a shared destination
                    if (m_we[s] && m_waddr[s] != 5'd0) begin
                        m_regs[m_waddr[s]] <= m_wdata[s];
                    end
                end
            end
            if (c_excp) begin
                m_era <= c_excp_pc;
            end
        end
    end

    // Ports 0 and 1 follow the destinations just written while 2 and 3 sweep the file
    always @(posedge clk) begin
        sweep_addr <= sweep_addr + 5'd1;
        raddr[0] <= m_waddr[0];
        raddr[1] <= m_waddr[1];
        raddr[2] <= sweep_addr;
        raddr[3] <= sweep_addr + 5'd16;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        err_count++;
        $display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
    endtask

    for (genvar k = 0; k < `CORE_READ_PORTS; k++) begin : g_read_check
        a_rdata: assert property (@(negedge clk) disable iff (!rst_n)
            rdata[k] == m_regs[raddr[k]])
            else report_mismatch($sformatf("rdata_o[%0d]", k), m_regs[raddr[k]], rdata[k]);
    end

    for (genvar s = 0; s < `CORE_COMMIT_W; s++) begin : g_trace_check
        a_pc: assert property (@(negedge clk) disable iff (!rst_n) dbg_pc[s] == m_dbg_pc[s])
            else report_mismatch($sformatf("debug%0d_wb_pc_o", s), m_dbg_pc[s], dbg_pc[s]);
        a_wen: assert property (@(negedge clk) disable iff (!rst_n) dbg_wen[s] == m_dbg_wen[s])
            else report_mismatch($sformatf("debug%0d_wb_rf_wen_o", s),
                                 32'(m_dbg_wen[s]), 32'(dbg_wen[s]));
        a_wnum: assert property (@(negedge clk) disable iff (!rst_n)
            dbg_wnum[s] == m_dbg_wnum[s])
            else report_mismatch($sformatf("debug%0d_wb_rf_wnum_o", s),
                                 32'(m_dbg_wnum[s]), 32'(dbg_wnum[s]));
        a_wdata: assert property (@(negedge clk) disable iff (!rst_n)
            dbg_wdata[s] == m_dbg_wdata[s])
            else report_mismatch($sformatf("debug%0d_wb_rf_wdata_o", s),
                                 m_dbg_wdata[s], dbg_wdata[s]);
    end

    a_next_pc: assert property (@(negedge clk) disable iff (!rst_n) next_pc == exp_next_pc)
        else report_mismatch("next_pc_o", exp_next_pc, next_pc);
    a_backend_flush: assert property (@(negedge clk) disable iff (!rst_n)
        backend_flush == exp_backend_flush)
        else report_mismatch("backend_flush_o", 32'(exp_backend_flush), 32'(backend_flush));
    a_era: assert property (@(negedge clk) disable iff (!rst_n) era == m_era)
        else report_mismatch("era_o", m_era, era);

    function automatic core_pkg::word_t random_word();
        return $random(seed);
    endfunction

    function automatic core_pkg::reg_addr_t random_addr();
        core_pkg::word_t w;
        w = random_word();
        return w[4:0];
    endfunction

    // Mostly normal slots with an exception or return now and then
    function automatic core_pkg::commit_kind_e random_kind();
        core_pkg::word_t w;
        w = random_word();
        if (w[2:0] == 3'd1) return core_pkg::CK_EXCP;
        if (w[2:0] == 3'd2) return core_pkg::CK_ERTN;
        return core_pkg::CK_NORMAL;
    endfunction

    task automatic clear_slots();
        mem_valid <= 2'b00;
        mem_we <= 2'b00;
        stall <= 1'b0;
        branch_flag <= 2'b00;
    endtask

    task automatic offer_slot(input int s, input core_pkg::commit_kind_e kind,
                              input core_pkg::ecode_t ecode, input logic we,
                              input core_pkg::reg_addr_t waddr);
        core_pkg::word_t pc_raw;
        pc_raw = random_word();
        mem_valid[s] <= 1'b1;
        mem_pc[s] <= {pc_raw[31:2], 2'b00};
        mem_kind[s] <= kind;
        mem_ecode[s] <= ecode;
        mem_we[s] <= we;
        mem_waddr[s] <= waddr;
        mem_wdata[s] <= random_word();
    endtask

    // Waits for a redirect or for a trace write when none is expected
    task automatic wait_for_event(input logic want_flush);
        int cycles;
        cycles = 0;
        while ((want_flush ? !backend_flush : !(dbg_wen[0][0] | dbg_wen[1][0]))
               && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 20) begin
            timeout_count++;
            $display("Timeout in %s: the expected commit event never showed up", test_name);
        end
    endtask

    task automatic run_pair(input core_pkg::commit_kind_e kind0,
                            input core_pkg::commit_kind_e kind1, input core_pkg::ecode_t ecode,
                            input core_pkg::reg_addr_t waddr0,
                            input core_pkg::reg_addr_t waddr1, input logic [1:0] bflag);
        @(posedge clk);
        offer_slot(0, kind0, ecode, 1'b1, waddr0);
        offer_slot(1, kind1, ecode, 1'b1, waddr1);
        @(posedge clk);
        clear_slots();
        branch_flag <= bflag;
        branch_target[0] <= random_word();
        branch_target[1] <= random_word();
        wait_for_event(kind0 != core_pkg::CK_NORMAL || kind1 != core_pkg::CK_NORMAL
                       || bflag != 2'b00);
        @(posedge clk);
        clear_slots();
    endtask

    initial begin
        core_pkg::reg_addr_t addr;
        core_pkg::word_t r;
        seed = 45743;
        err_count = 0;
        timeout_count = 0;
        test_name = "reset";
        rst_n <= 1'b0;
        clear_slots();
        eentry <= 32'h1c00_8000;
        tlbrentry <= 32'h1c00_f000;
        for (int s = 0; s < `CORE_COMMIT_W; s++) begin
            mem_pc[s] <= '0;
            mem_kind[s] <= core_pkg::CK_NORMAL;
            mem_ecode[s] <= '0;
            mem_waddr[s] <= '0;
            mem_wdata[s] <= '0;
            branch_target[s] <= '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "dual_commit";
        for (int n = 0; n < 30; n++) begin
            run_pair(core_pkg::CK_NORMAL, core_pkg::CK_NORMAL, 6'h00,
                     random_addr(), random_addr(), 2'b00);
        end

        test_name = "same_dest";
        addr = random_addr() | 5'd1;
        run_pair(core_pkg::CK_NORMAL, core_pkg::CK_NORMAL, 6'h00, addr, addr, 2'b00);
        run_pair(core_pkg::CK_NORMAL, core_pkg::CK_NORMAL, 6'h00, 5'd0, 5'd0, 2'b00);

        test_name = "exceptions";
        run_pair(core_pkg::CK_EXCP, core_pkg::CK_NORMAL, 6'h01,
                 random_addr(), random_addr(), 2'b00);
        run_pair(core_pkg::CK_EXCP, core_pkg::CK_NORMAL, 6'h3F,
                 random_addr(), random_addr(), 2'b00);
        run_pair(core_pkg::CK_NORMAL, core_pkg::CK_EXCP, 6'h05,
                 random_addr(), random_addr(), 2'b00);

        test_name = "ertn";
        run_pair(core_pkg::CK_ERTN, core_pkg::CK_NORMAL, 6'h00,
                 random_addr(), random_addr(), 2'b00);

        test_name = "redirect_priority";
        run_pair(core_pkg::CK_EXCP, core_pkg::CK_NORMAL, 6'h02,
                 random_addr(), random_addr(), 2'b10);
        run_pair(core_pkg::CK_NORMAL, core_pkg::CK_NORMAL, 6'h00,
                 random_addr(), random_addr(), 2'b11);
        run_pair(core_pkg::CK_ERTN, core_pkg::CK_NORMAL, 6'h00,
                 random_addr(), random_addr(), 2'b01);

        test_name = "stall";
        for (int n = 0; n < 20; n++) begin
            @(posedge clk);
            stall <= 1'b1;
            offer_slot(0, core_pkg::CK_NORMAL, 6'h00, 1'b1, random_addr());
            offer_slot(1, core_pkg::CK_NORMAL, 6'h00, 1'b1, random_addr());
        end
        @(posedge clk);
        clear_slots();

        test_name = "random_stream";
        for (int n = 0; n < 200; n++) begin
            @(posedge clk);
            r = random_word();
            offer_slot(0, random_kind(), r[0] ? 6'h3F : r[6:1], r[7], random_addr());
            offer_slot(1, random_kind(), r[19] ? 6'h3F : r[25:20], r[8], random_addr());
            mem_valid <= r[17:16] | {1'b0, r[18]};
            stall <= (r[10:9] == 2'b00);
            branch_flag <= (r[13:11] == 3'b000) ? r[15:14] : 2'b00;
            branch_target[0] <= random_word();
            branch_target[1] <= random_word();
        end
        @(posedge clk);
        clear_slots();

        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hw/core_pkg.sv
hw/wb_stage.sv
hw/commit_ctrl.sv
hw/regfile.sv
hw/commit_top.sv
testbench/tb_commit_top.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail

# Compile and run the commit testbench with Verilator
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_commit_top \
    -f filelist.f \
    -o tb_commit_top

./obj_dir/tb_commit_top 2>&1 | tee "$LOG"

if grep -q "Verification failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
    exit 1
fi
